//--- filelist.f
+incdir+source
source/soc_bus_pkg.sv
source/soc_periph_pkg.sv
source/rst_ctrl.sv
source/wb_decoder.sv
source/gpio_ctrl.sv
source/uart_ctrl.sv
source/board_top.sv
tb/tb_clk_gen.sv
tb/tb_board_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the board testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_board_top -f filelist.f -o tb_board_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_board_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi

//--- tb/tb_board_top.sv
`include "soc_macros.svh"

module tb_board_top
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int BUS_LIMIT    = 200;
  localparam int POLL_LIMIT   = 200;
  localparam int BIT_LIMIT    = 64;
  localparam int UNMAPPED_ADR = 3;

  // Worst-case cycles of each test doubled for the run limit
  localparam int FRAME_DEF = 10 * `UART_DEFAULT_DIV;
  localparam int T_RESET   = 8 + `RST_HOLD_CYCLES + 40;
  localparam int T_GPIO    = 40;
  localparam int T_LOOP    = 4 * (FRAME_DEF + 30);
  localparam int T_BACKP   = 3 * FRAME_DEF + 80;
  localparam int T_DIV     = 10 * 12 + 60;
  localparam int T_UNMAP   = 10;
  localparam int TIMEOUT_CYCLES =
    2 * (T_RESET + T_GPIO + T_LOOP + T_BACKP + T_DIV + T_UNMAP);

  logic                   clk;
  logic                   rst;
  logic                   pll_lock;
  wb_req_t                wb_req;
  wb_rsp_t                wb_rsp;
  wire [`SOC_GPIO_W-1:0]  gpio_pins;
  logic [`SOC_GPIO_W-1:0] pin_en;
  logic [`SOC_GPIO_W-1:0] pin_val;
  logic                   uart_line;
  logic [31:0]            lfsr_state;
  int                     error_count;
  int                     check_count;
  int                     cycle_count = 0;

  tb_clk_gen u_clk_gen (
    .o_clk (clk)
  );

  // Serial output loops straight back into the receiver
  board_top u_board_top (
    .i_sclk     (clk),
    .i_rst      (rst),
    .i_pll_lock (pll_lock),
    .i_wb_req   (wb_req),
    .o_wb_rsp   (wb_rsp),
    .io_gpio    (gpio_pins),
    .i_uart_rd  (uart_line),
    .o_uart_td  (uart_line)
  );

  // Board-side drivers for the DIP switches and a probe on the LEDs
  for (genvar i = 0; i < `SOC_GPIO_W; i++) begin : g_pin_drv
    assign gpio_pins[i] = pin_en[i] ? pin_val[i] : 1'bz;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Input register layout with raw pins low and each field at its own offset
  function automatic logic [31:0] gpio_in_word(input logic [7:0] leds, input logic [3:0] dips);
    logic [31:0] w;
    w        = '0;
    w[11:0]  = {leds, dips};
    w[19:16] = dips;
    w[31:24] = leds;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      $display("Test %s done, no errors", name);
    end else begin
      $display("Test %s done, %0d errors", name, error_count - errs_before);
    end
  endtask

  // Starts just after a falling edge and returns after one idle cycle
  task automatic wb_access(input logic we, input int adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic got_ack,
                           output logic got_err, output int cycles);
    cycles  = 0;
    got_ack = 1'b0;
    got_err = 1'b0;
    rdat    = '0;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = `SOC_ADDR_W'(adr);
    wb_req.dat = wdat;
    while (!got_ack && !got_err && cycles < BUS_LIMIT) begin
      @(negedge clk);
      cycles++;
      got_ack = wb_rsp.ack;
      got_err = wb_rsp.err;
      rdat    = wb_rsp.dat;
    end
    wb_req = '0;
    @(negedge clk);
    if (!got_ack && !got_err) begin
      error_count++;
      $display("Bus access to address %0d got no response within %0d cycles", adr, BUS_LIMIT);
    end
  endtask

  task automatic wb_write(input int adr, input logic [31:0] dat, output int cycles);
    logic [31:0] rdat;
    logic        got_ack;
    logic        got_err;
    wb_access(1'b1, adr, dat, rdat, got_ack, got_err, cycles);
    if (got_err) begin
      error_count++;
      $display("Write to address %0d was answered with err", adr);
    end
  endtask

  task automatic wb_read(input int adr, output logic [31:0] dat, output int cycles);
    logic got_ack;
    logic got_err;
    wb_access(1'b0, adr, '0, dat, got_ack, got_err, cycles);
    if (got_err) begin
      error_count++;
      $display("Read of address %0d was answered with err", adr);
    end
  endtask

  // Polls status until a byte is waiting and collects any overrun seen
  task automatic wait_rx_byte(output logic ovr);
    logic [31:0] d;
    int          lat;
    int          polls;
    uart_stat_t  st;
    polls = 0;
    st    = '0;
    ovr   = 1'b0;
    while (!st.rx_valid && polls < POLL_LIMIT) begin
      wb_read(`REG_UART_STAT, d, lat);
      st  = d[3:0];
      ovr = ovr | st.rx_overrun;
      polls++;
    end
    if (!st.rx_valid) begin
      error_count++;
      $display("UART receiver reported no byte after %0d status reads", polls);
    end
  endtask

  task automatic reset_lock_gating();
    int          errs;
    int          lat;
    logic [31:0] r;
    logic [31:0] d;
    errs = error_count;
    // Board drives every pin while the DUT direction is all inputs
    take_random_bits(`SOC_GPIO_W, r);
    pin_val  = r[`SOC_GPIO_W-1:0];
    pin_en   = '1;
    pll_lock = 1'b0;
    repeat (5) @(negedge clk);
    check_value("o_wb_rsp.ack", 32'(wb_rsp.ack), 0);
    check_value("o_wb_rsp.err", 32'(wb_rsp.err), 0);
    check_value("o_uart_td", 32'(uart_line), 1);
    // Lock returns and a read goes out in the same cycle
    pll_lock = 1'b1;
    wb_read(`REG_GPIO_DIR, d, lat);
    check_value("ack latency after lock", lat, `RST_HOLD_CYCLES + 1);
    check_value("GPIO_DIR", d, 0);
    wb_read(`REG_GPIO_OUT, d, lat);
    check_value("GPIO_OUT", d, 0);
    wb_read(`REG_UART_DIV, d, lat);
    check_value("UART_DIV", d, `UART_DEFAULT_DIV);
    wb_read(`REG_UART_STAT, d, lat);
    check_value("UART_STAT", d, 0);
    wb_read(`REG_GPIO_IN, d, lat);
    check_value("GPIO_IN", d, gpio_in_word(pin_val[11:4], pin_val[3:0]));
    finish_test("reset and lock gating", errs);
  endtask

  task automatic gpio_out_and_in();
    int          errs;
    int          lat;
    logic [31:0] r;
    logic [31:0] d;
    logic [11:0] out_val;
    errs = error_count;
    // Release the LED pins before the DUT takes them
    pin_en = {8'h00, 4'hf};
    wb_write(`REG_GPIO_DIR, 32'h0000_0ff0, lat);
    take_random_bits(`SOC_GPIO_W, r);
    out_val = r[11:0];
    wb_write(`REG_GPIO_OUT, 32'(out_val), lat);
    check_value("io_gpio[11:4]", 32'(gpio_pins[11:4]), 32'(out_val[11:4]));
    wb_read(`REG_GPIO_OUT, d, lat);
    check_value("GPIO_OUT", d, 32'(out_val));
    take_random_bits(4, r);
    pin_val[3:0] = r[3:0];
    // Two synchronizer flops plus the read sample
    repeat (3) @(negedge clk);
    wb_read(`REG_GPIO_IN, d, lat);
    check_value("GPIO_IN", d, gpio_in_word(out_val[11:4], r[3:0]));
    finish_test("GPIO output and input", errs);
  endtask

  task automatic uart_loopback();
    int          errs;
    int          lat;
    logic [31:0] r;
    logic [31:0] d;
    logic        ovr;
    errs = error_count;
    for (int i = 0; i < 4; i++) begin
      take_random_bits(8, r);
      wb_write(`REG_UART_DATA, 32'(r[7:0]), lat);
      wait_rx_byte(ovr);
      check_value("rx_overrun", 32'(ovr), 0);
      wb_read(`REG_UART_DATA, d, lat);
      check_value("UART_DATA", d, 32'(r[7:0]));
    end
    finish_test("UART loopback", errs);
  endtask

  task automatic tx_backpressure();
    int          errs;
    int          lat;
    int          lat2;
    int          polls;
    logic [31:0] r;
    logic [31:0] d;
    logic [7:0]  b0;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic        ovr;
    logic        idle;
    uart_stat_t  st;
    errs = error_count;
    take_random_bits(8, r);
    b0 = r[7:0];
    take_random_bits(8, r);
    b1 = r[7:0];
    take_random_bits(8, r);
    b2 = r[7:0];
    wb_write(`REG_UART_DATA, 32'(b0), lat);
    wb_write(`REG_UART_DATA, 32'(b1), lat);
    wb_write(`REG_UART_DATA, 32'(b2), lat2);
    check_count++;
    if (lat2 <= 1) begin
      error_count++;
      $display("Third UART write was acked after %0d cycle with the holding byte full",
               lat2);
    end
    wait_rx_byte(ovr);
    check_value("rx_overrun", 32'(ovr), 0);
    wb_read(`REG_UART_DATA, d, lat);
    check_value("UART_DATA first byte", d, 32'(b0));
    // Buffer stays unread while the last two bytes land
    ovr   = 1'b0;
    idle  = 1'b0;
    polls = 0;
    while (!idle && polls < POLL_LIMIT) begin
      wb_read(`REG_UART_STAT, d, lat);
      st    = d[3:0];
      ovr   = ovr | st.rx_overrun;
      idle  = !st.tx_busy && !st.tx_full;
      polls++;
    end
    if (!idle) begin
      error_count++;
      $display("UART transmitter still busy after %0d status reads", polls);
    end
    wb_read(`REG_UART_DATA, d, lat);
    check_value("UART_DATA last byte", d, 32'(b2));
    check_value("rx_overrun seen", 32'(ovr), 1);
    wb_read(`REG_UART_STAT, d, lat);
    check_value("UART_STAT after read", d, 0);
    finish_test("transmit back-pressure", errs);
  endtask

  task automatic divisor_change();
    int          errs;
    int          lat;
    int          new_div;
    int          n;
    int          low;
    logic [31:0] r;
    logic [31:0] d;
    logic [7:0]  b;
    logic        ovr;
    errs = error_count;
    take_random_bits(3, r);
    new_div = 5 + int'(r[2:0]);
    wb_write(`REG_UART_DIV, 32'(new_div), lat);
    wb_read(`REG_UART_DIV, d, lat);
    check_value("UART_DIV", d, 32'(new_div));
    // Bit 0 set so the start bit ends on a rising edge
    take_random_bits(8, r);
    b = r[7:0] | 8'h01;
    wb_write(`REG_UART_DATA, 32'(b), lat);
    n = 0;
    while (uart_line && n < BIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (uart_line) begin
      error_count++;
      $display("No start bit appeared on o_uart_td within %0d cycles", BIT_LIMIT);
    end else begin
      low = 0;
      while (!uart_line && low < BIT_LIMIT) begin
        @(negedge clk);
        low++;
      end
      check_value("start bit cycles", low, 32'(new_div));
    end
    wait_rx_byte(ovr);
    check_value("rx_overrun", 32'(ovr), 0);
    wb_read(`REG_UART_DATA, d, lat);
    check_value("UART_DATA", d, 32'(b));
    finish_test("divisor", errs);
  endtask

  task automatic unmapped_access();
    int          errs;
    int          lat;
    logic [31:0] r;
    logic [31:0] d;
    logic        got_ack;
    logic        got_err;
    errs = error_count;
    wb_access(1'b0, UNMAPPED_ADR, '0, d, got_ack, got_err, lat);
    check_value("read o_wb_rsp.ack", 32'(got_ack), 0);
    check_value("read o_wb_rsp.err", 32'(got_err), 1);
    check_value("read o_wb_rsp.dat", d, 0);
    check_value("read err latency", lat, 1);
    take_random_bits(32, r);
    wb_access(1'b1, UNMAPPED_ADR, r, d, got_ack, got_err, lat);
    check_value("write o_wb_rsp.ack", 32'(got_ack), 0);
    check_value("write o_wb_rsp.err", 32'(got_err), 1);
    check_value("write o_wb_rsp.dat", d, 0);
    check_value("write err latency", lat, 1);
    finish_test("unmapped access", errs);
  endtask

  initial begin
    lfsr_state  = 32'h7a84;
    error_count = 0;
    check_count = 0;
    rst         = 1'b1;
    pll_lock    = 1'b1;
    wb_req      = '0;
    pin_en      = '0;
    pin_val     = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    reset_lock_gating();
    gpio_out_and_in();
    uart_loopback();
    tx_backpressure();
    divisor_change();
    unmapped_access();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb/tb_clk_gen.sv
module tb_clk_gen (
  output logic o_clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

endmodule

//--- source/board_top.sv
`include "soc_macros.svh"

module board_top
  import soc_bus_pkg::*;
(
  // Board clock, single-ended
  input  logic                   i_sclk,
  // External reset, active high
  input  logic                   i_rst,
  input  logic                   i_pll_lock,
  // Host bus port standing in for the CPU master
  input  wb_req_t                i_wb_req,
  output wb_rsp_t                o_wb_rsp,
  // GPIO: [11:4] LEDs, [3:0] DIP switches
  inout  wire [`SOC_GPIO_W-1:0]  io_gpio,
  // UART serial line
  input  logic                   i_uart_rd,
  output logic                   o_uart_td
);

  logic    w_sys_rst;
  wb_req_t wb_gpio_req;
  wb_rsp_t wb_gpio_rsp;
  wb_req_t wb_uart_req;
  wb_rsp_t wb_uart_rsp;

  rst_ctrl rst0 (
    .i_sclk     (i_sclk),
    .i_rst      (i_rst),
    .i_pll_lock (i_pll_lock),
    .o_sys_rst  (w_sys_rst)
  );

  wb_decoder dec0 (
    .i_sclk     (i_sclk),
    .i_rst      (w_sys_rst),
    .i_wb_req   (i_wb_req),
    .o_wb_rsp   (o_wb_rsp),
    .o_gpio_req (wb_gpio_req),
    .i_gpio_rsp (wb_gpio_rsp),
    .o_uart_req (wb_uart_req),
    .i_uart_rsp (wb_uart_rsp)
  );

  gpio_ctrl gpio0 (
    .i_sclk  (i_sclk),
    .i_rst   (w_sys_rst),
    .i_req   (wb_gpio_req),
    .o_rsp   (wb_gpio_rsp),
    .io_gpio (io_gpio)
  );

  uart_ctrl uart0 (
    .i_sclk    (i_sclk),
    .i_rst     (w_sys_rst),
    .i_req     (wb_uart_req),
    .o_rsp     (wb_uart_rsp),
    .i_uart_rd (i_uart_rd),
    .o_uart_td (o_uart_td)
  );

endmodule

//--- source/uart_ctrl.sv
`include "soc_macros.svh"

module uart_ctrl
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;
(
  input  logic    i_sclk,
  input  logic    i_rst,
  input  wb_req_t i_req,
  output wb_rsp_t o_rsp,
  input  logic    i_uart_rd,
  output logic    o_uart_td
);

  localparam int DIV_W = 16;

  logic [DIV_W-1:0]       div_q;
  logic                   ack_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   req_go;
  logic                   wr_data;
  logic                   rd_data;
  logic                   rd_stat;
  logic                   accept;
  uart_stat_t             stat;

  logic                   hold_full;
  logic [7:0]             hold_byte;
  logic                   tx_busy;
  logic [9:0]             tx_frame;
  logic [3:0]             tx_bits;
  logic [DIV_W-1:0]       tx_cnt;

  logic [1:0]             rx_sync;
  logic                   rx_in;
  logic                   rx_busy;
  logic [3:0]             rx_bits;
  logic [DIV_W-1:0]       rx_cnt;
  logic [7:0]             rx_shift;
  logic [7:0]             rx_data;
  logic                   rx_valid;
  logic                   rx_overrun;
  logic                   rx_done;

  assign req_go  = i_req.cyc & i_req.stb & ~ack_q;
  assign wr_data = req_go & i_req.we & (reg_idx_e'(i_req.adr) == IDX_UART_DATA);
  assign rd_data = req_go & ~i_req.we & (reg_idx_e'(i_req.adr) == IDX_UART_DATA);
  assign rd_stat = req_go & ~i_req.we & (reg_idx_e'(i_req.adr) == IDX_UART_STAT);
  // A data write stalls while the holding byte is still waiting
  assign accept  = req_go & ~(wr_data & hold_full);

  assign stat.tx_busy    = tx_busy;
  assign stat.tx_full    = hold_full;
  assign stat.rx_valid   = rx_valid;
  assign stat.rx_overrun = rx_overrun;

  always_ff @(posedge i_sclk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
      div_q <= DIV_W'(`UART_DEFAULT_DIV);
    end else begin
      ack_q <= accept;
      if (accept && i_req.we && reg_idx_e'(i_req.adr) == IDX_UART_DIV) begin
        div_q <= i_req.dat[DIV_W-1:0];
      end
    end
  end

  always_ff @(posedge i_sclk) begin
    case (reg_idx_e'(i_req.adr))
      IDX_UART_DATA: rdata_q <= `SOC_DATA_W'(rx_data);
      IDX_UART_STAT: rdata_q <= `SOC_DATA_W'(stat);
      IDX_UART_DIV:  rdata_q <= `SOC_DATA_W'(div_q);
      default:       rdata_q <= '0;
    endcase
  end

  always_ff @(posedge i_sclk) begin
    if (accept && wr_data) begin
      hold_byte <= i_req.dat[7:0];
    end
  end

  // Transmit shifter holding stop bit, data LSB first and start bit
  always_ff @(posedge i_sclk) begin
    if (i_rst) begin
      hold_full <= 1'b0;
      tx_busy   <= 1'b0;
      tx_frame  <= '1;
      tx_bits   <= '0;
      tx_cnt    <= '0;
    end else begin
      if (accept && wr_data) begin
        hold_full <= 1'b1;
      end
      if (!tx_busy && hold_full) begin
        hold_full <= 1'b0;
        tx_busy   <= 1'b1;
        tx_frame  <= {1'b1, hold_byte, 1'b0};
        tx_bits   <= 4'd10;
        tx_cnt    <= div_q - 1'b1;
      end else if (tx_busy) begin
        if (tx_cnt == '0) begin
          tx_frame <= {1'b1, tx_frame[9:1]};
          tx_bits  <= tx_bits - 1'b1;
          tx_cnt   <= div_q - 1'b1;
          if (tx_bits == 4'd1) begin
            tx_busy <= 1'b0;
          end
        end else begin
          tx_cnt <= tx_cnt - 1'b1;
        end
      end
    end
  end

  assign o_uart_td = tx_frame[0];

  assign rx_in   = rx_sync[1];
  assign rx_done = rx_busy & (rx_cnt == '0) & (rx_bits == 4'd9) & rx_in;

  // Receiver samples near the middle of each bit
  always_ff @(posedge i_sclk) begin
    if (i_rst) begin
      rx_sync <= 2'b11;
      rx_busy <= 1'b0;
      rx_bits <= '0;
      rx_cnt  <= '0;
    end else begin
      rx_sync <= {rx_sync[0], i_uart_rd};
      if (!rx_busy) begin
        if (!rx_in) begin
          rx_busy <= 1'b1;
          rx_bits <= '0;
          rx_cnt  <= div_q >> 1;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt  <= div_q - 1'b1;
        rx_bits <= rx_bits + 1'b1;
        // Start bit gone high again means a glitch
        if ((rx_bits == 4'd0 && rx_in) || rx_bits == 4'd9) begin
          rx_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge i_sclk) begin
    if (rx_busy && rx_cnt == '0 && rx_bits != 4'd0 && rx_bits != 4'd9) begin
      rx_shift <= {rx_in, rx_shift[7:1]};
    end
    if (rx_done) begin
      rx_data <= rx_shift;
    end
  end

  // New byte wins over a read clearing valid in the same cycle
  always_ff @(posedge i_sclk) begin
    if (i_rst) begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end else begin
      if (rd_data) begin
        rx_valid <= 1'b0;
      end
      if (rd_stat) begin
        rx_overrun <= 1'b0;
      end
      if (rx_done) begin
        rx_valid <= 1'b1;
        if (rx_valid && !rd_data) begin
          rx_overrun <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    o_rsp.ack = ack_q;
    o_rsp.err = 1'b0;
    o_rsp.dat = rdata_q;
  end

endmodule

//--- source/gpio_ctrl.sv
`include "soc_macros.svh"

module gpio_ctrl
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;
(
  input  logic                   i_sclk,
  input  logic                   i_rst,
  input  wb_req_t                i_req,
  output wb_rsp_t                o_rsp,
  inout  wire [`SOC_GPIO_W-1:0]  io_gpio
);

  logic [`SOC_GPIO_W-1:0] out_q;
  logic [`SOC_GPIO_W-1:0] dir_q;
  logic [`SOC_GPIO_W-1:0] pin_meta;
  gpio_word_u             pin_sync;
  logic                   ack_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   req_go;

  assign req_go = i_req.cyc & i_req.stb & ~ack_q;

  // Pin drives its output bit only where direction is set
  for (genvar i = 0; i < `SOC_GPIO_W; i++) begin : g_pin
    assign io_gpio[i] = dir_q[i] ? out_q[i] : 1'bz;
  end

  // Two-flop input synchronizer
  always_ff @(posedge i_sclk) begin
    pin_meta     <= io_gpio;
    pin_sync.raw <= pin_meta;
  end

  always_ff @(posedge i_sclk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
      out_q <= '0;
      dir_q <= '0;
    end else begin
      ack_q <= req_go;
      if (req_go && i_req.we) begin
        case (reg_idx_e'(i_req.adr))
          IDX_GPIO_OUT: out_q <= i_req.dat[`SOC_GPIO_W-1:0];
          IDX_GPIO_DIR: dir_q <= i_req.dat[`SOC_GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Input word carries raw pins plus both fields at fixed offsets
  always_ff @(posedge i_sclk) begin
    case (reg_idx_e'(i_req.adr))
      IDX_GPIO_OUT: rdata_q <= `SOC_DATA_W'(out_q);
      IDX_GPIO_DIR: rdata_q <= `SOC_DATA_W'(dir_q);
      IDX_GPIO_IN: begin
        rdata_q <= {pin_sync.f.leds, 4'd0, pin_sync.f.dips, 4'd0, pin_sync.raw};
      end
      default: rdata_q <= '0;
    endcase
  end

  always_comb begin
    o_rsp.ack = ack_q;
    o_rsp.err = 1'b0;
    o_rsp.dat = rdata_q;
  end

endmodule

//--- source/wb_decoder.sv
`include "soc_macros.svh"

module wb_decoder
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;
(
  input  logic    i_sclk,
  input  logic    i_rst,
  input  wb_req_t i_wb_req,
  output wb_rsp_t o_wb_rsp,
  output wb_req_t o_gpio_req,
  input  wb_rsp_t i_gpio_rsp,
  output wb_req_t o_uart_req,
  input  wb_rsp_t i_uart_rsp
);

  logic gpio_sel;
  logic uart_sel;
  logic err_q;

  always_comb begin
    gpio_sel = 1'b0;
    uart_sel = 1'b0;
    case (reg_idx_e'(i_wb_req.adr))
      IDX_GPIO_OUT, IDX_GPIO_DIR, IDX_GPIO_IN: gpio_sel = 1'b1;
      IDX_UART_DATA, IDX_UART_STAT, IDX_UART_DIV: uart_sel = 1'b1;
      default: ;
    endcase
  end

  // Targets see the request with stb qualified by their select
  always_comb begin
    o_gpio_req     = i_wb_req;
    o_gpio_req.stb = i_wb_req.stb & gpio_sel;
    o_uart_req     = i_wb_req;
    o_uart_req.stb = i_wb_req.stb & uart_sel;
  end

  // Unmapped word gets a single err pulse
  always_ff @(posedge i_sclk) begin
    if (i_rst) begin
      err_q <= 1'b0;
    end else begin
      err_q <= i_wb_req.cyc & i_wb_req.stb & ~gpio_sel & ~uart_sel & ~err_q;
    end
  end

  always_comb begin
    o_wb_rsp.ack = i_gpio_rsp.ack | i_uart_rsp.ack;
    o_wb_rsp.err = err_q | i_gpio_rsp.err | i_uart_rsp.err;
    if (gpio_sel) begin
      o_wb_rsp.dat = i_gpio_rsp.dat;
    end else if (uart_sel) begin
      o_wb_rsp.dat = i_uart_rsp.dat;
    end else begin
      o_wb_rsp.dat = '0;
    end
  end

endmodule

//--- source/rst_ctrl.sv
`include "soc_macros.svh"

module rst_ctrl (
  input  logic i_sclk,
  input  logic i_rst,
  input  logic i_pll_lock,
  output logic o_sys_rst
);

  localparam int CNT_W = $clog2(`RST_HOLD_CYCLES + 1);

  logic [1:0]       lock_sync;
  logic [CNT_W-1:0] hold_cnt;
  logic             fault;

  // Either source forces reset on the next edge
  assign fault = i_rst | ~i_pll_lock;

  always_ff @(posedge i_sclk) begin
    lock_sync <= {lock_sync[0], i_pll_lock};
  end

  // Release only after the hold count and a synchronized lock
  always_ff @(posedge i_sclk) begin
    if (fault) begin
      hold_cnt  <= '0;
      o_sys_rst <= 1'b1;
    end else begin
      if (hold_cnt != CNT_W'(`RST_HOLD_CYCLES)) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
      o_sys_rst <= (hold_cnt < CNT_W'(`RST_HOLD_CYCLES - 1)) | ~lock_sync[1];
    end
  end

endmodule

//--- source/soc_periph_pkg.sv
`include "soc_macros.svh"

package soc_periph_pkg;

  // Board view of the pins, LEDs on top and DIP switches below
  typedef struct packed {
    logic [7:0] leds;
    logic [3:0] dips;
  } gpio_fields_t;

  // Same pin word seen either raw or split into its fields
  typedef union packed {
    logic [`SOC_GPIO_W-1:0] raw;
    gpio_fields_t           f;
  } gpio_word_u;

  // UART status register, bit 3 down to bit 0
  typedef struct packed {
    logic tx_busy;
    logic tx_full;
    logic rx_valid;
    logic rx_overrun;
  } uart_stat_t;

  typedef enum logic [`SOC_ADDR_W-1:0] {
    IDX_GPIO_OUT  = `REG_GPIO_OUT,
    IDX_GPIO_DIR  = `REG_GPIO_DIR,
    IDX_GPIO_IN   = `REG_GPIO_IN,
    IDX_UART_DATA = `REG_UART_DATA,
    IDX_UART_STAT = `REG_UART_STAT,
    IDX_UART_DIV  = `REG_UART_DIV
  } reg_idx_e;

endpackage

//--- source/soc_bus_pkg.sv
`include "soc_macros.svh"

package soc_bus_pkg;

  // Wishbone classic request held by the master until ack or err
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] adr;
    logic [`SOC_DATA_W-1:0] dat;
  } wb_req_t;

  // Wishbone response with single-cycle ack and err pulses
  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`SOC_DATA_W-1:0] dat;
  } wb_rsp_t;

endpackage

//--- source/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// Bus and pin widths
`define SOC_ADDR_W        8
`define SOC_DATA_W        32
`define SOC_GPIO_W        12

// Cycles the system reset is held after lock and reset are clean
`define RST_HOLD_CYCLES   16

// Clocks per UART bit after reset
`define UART_DEFAULT_DIV  8

// Register word addresses
`define REG_GPIO_OUT      0
`define REG_GPIO_DIR      1
`define REG_GPIO_IN       2
`define REG_UART_DATA     4
`define REG_UART_STAT     5
`define REG_UART_DIV      6

`endif
